// File: source/cluster_ctrl_pkg.sv
// cluster control package with bus widths, AXI-Lite channel structs and the eoc word layout
`default_nettype none

package cluster_ctrl_pkg;

  // register and bus data width
  localparam int unsigned DataWidth = 32;
  // one strobe bit per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;
  // byte address space of the control block
  localparam int unsigned AddrWidth = 8;
  // eoc, wake_up, tcdm_start, tcdm_end, num_cores
  localparam int unsigned NumRegs   = 5;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // AXI response codes, only the two used by this slave
  typedef logic [1:0] resp_t;
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // master to slave, all five channels flattened
  typedef struct packed {
    addr_t aw_addr;
    logic  aw_valid;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } axi_lite_req_t;

  // slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_t b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_t r_resp;
  } axi_lite_resp_t;

  // eoc register, stored as a plain word
  // decoded as return code in the upper bits and valid in bit 0
  typedef union packed {
    data_t raw;
    struct packed {
      logic [DataWidth-2:0] code;
      logic                 valid;
    } fields;
  } eoc_word_u;

endpackage

`default_nettype wire

// File: source/axi_lite_regs.sv
// generic AXI-Lite register file with byte strobes, read-only bytes and write activity flags
`default_nettype none

module axi_lite_regs
  import cluster_ctrl_pkg::*;
#(
  // total register bytes, a multiple of the word size
  parameter int unsigned                 RegNumBytes  = NumRegs * StrbWidth,
  // one bit per byte, set means the bus cannot write it
  parameter logic [RegNumBytes-1:0]      ReadOnlyMask = '0,
  // value of every byte after reset
  parameter logic [RegNumBytes-1:0][7:0] RegRstVal    = '0
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  axi_lite_req_t                  axi_req_i,
  output axi_lite_resp_t                 axi_resp_o,
  output logic [RegNumBytes-1:0]         wr_active_o,
  output logic [RegNumBytes-1:0][7:0]    reg_q_o
);

  localparam int unsigned NumWords = RegNumBytes / StrbWidth;
  // word index, low two address bits dropped
  localparam int unsigned IdxWidth = AddrWidth - 2;

  typedef logic [IdxWidth-1:0] idx_t;

  // write path
  idx_t  wr_idx;
  logic  wr_hit;
  strb_t wr_ro;
  logic  wr_err;
  logic  wr_fire;
  logic  b_valid_q;
  resp_t b_resp_q;

  // read path
  idx_t  rd_idx;
  logic  rd_hit;
  data_t rd_word;
  logic  rd_fire;
  logic  r_valid_q;
  data_t r_data_q;
  resp_t r_resp_q;

  assign wr_idx = axi_req_i.aw_addr[AddrWidth-1:2];
  assign rd_idx = axi_req_i.ar_addr[AddrWidth-1:2];

  // anything past the last word is outside the map
  assign wr_hit = (wr_idx < idx_t'(NumWords));
  assign rd_hit = (rd_idx < idx_t'(NumWords));

  // read-only bits of the addressed word
  always_comb begin
    wr_ro = '0;
    for (int unsigned w = 0; w < NumWords; w++) begin
      if (wr_idx == idx_t'(w)) begin
        wr_ro = ReadOnlyMask[w*StrbWidth +: StrbWidth];
      end
    end
  end

  // a single strobed read-only byte rejects the whole write
  assign wr_err = !wr_hit || ((wr_ro & axi_req_i.w_strb) != '0);

  // address and data are taken in the same cycle
  // blocked while a write response is still waiting for b_ready
  assign wr_fire = axi_req_i.aw_valid && axi_req_i.w_valid && !b_valid_q;

  // per-byte write enables, also reported to the owner of the map
  always_comb begin
    wr_active_o = '0;
    for (int unsigned i = 0; i < RegNumBytes; i++) begin
      wr_active_o[i] = wr_fire && !wr_err
                       && (wr_idx == idx_t'(i / StrbWidth))
                       && axi_req_i.w_strb[i % StrbWidth];
    end
  end

  // register bytes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_q_o <= RegRstVal;
    end else begin
      for (int unsigned i = 0; i < RegNumBytes; i++) begin
        if (wr_active_o[i]) begin
          reg_q_o[i] <= axi_req_i.w_data[8*(i % StrbWidth) +: 8];
        end
      end
    end
  end

  // write response valid, held until b_ready
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_fire) begin
      b_valid_q <= 1'b1;
    end else if (axi_req_i.b_ready) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_err ? RespSlvErr : RespOkay;
    end
  end

  // word mux for reads, zero outside the map
  always_comb begin
    rd_word = '0;
    for (int unsigned w = 0; w < NumWords; w++) begin
      if (rd_idx == idx_t'(w)) begin
        rd_word = reg_q_o[w*StrbWidth +: StrbWidth];
      end
    end
  end

  // one read in flight at most
  assign rd_fire = axi_req_i.ar_valid && !r_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_fire) begin
      r_valid_q <= 1'b1;
    end else if (axi_req_i.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // read payload, captured at the ar handshake
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= rd_word;
      r_resp_q <= rd_hit ? RespOkay : RespSlvErr;
    end
  end

  always_comb begin
    // aw and w are accepted together
    // a lone aw_valid or w_valid sees its ready low so neither side fires alone
    axi_resp_o.aw_ready = !b_valid_q && !(axi_req_i.aw_valid && !axi_req_i.w_valid);
    axi_resp_o.w_ready  = !b_valid_q && !(axi_req_i.w_valid && !axi_req_i.aw_valid);
    axi_resp_o.b_valid  = b_valid_q;
    axi_resp_o.b_resp   = b_resp_q;
    axi_resp_o.ar_ready = !r_valid_q;
    axi_resp_o.r_valid  = r_valid_q;
    axi_resp_o.r_data   = r_data_q;
    axi_resp_o.r_resp   = r_resp_q;
  end

endmodule

`default_nettype wire

// File: source/ctrl_registers.sv
// cluster control register map with eoc decode and per-core wake-up pulse generation
`default_nettype none

module ctrl_registers
  import cluster_ctrl_pkg::*;
#(
  // cores in the cluster, 1 to 32
  parameter int unsigned NumCores     = 8,
  // tightly coupled data memory window
  parameter data_t       TcdmBaseAddr = 32'h1000_0000,
  parameter data_t       TcdmSize     = 32'h0001_0000
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  axi_lite_req_t        axi_lite_req_i,
  output axi_lite_resp_t       axi_lite_resp_o,
  output logic [DataWidth-2:0] eoc_code_o,
  output logic                 eoc_valid_o,
  output logic [NumCores-1:0]  wake_up_o,
  output data_t                tcdm_start_addr_o,
  output data_t                tcdm_end_addr_o,
  output data_t                num_cores_o
);

  localparam int unsigned RegNumBytes = NumRegs * StrbWidth;
  // word index of the wake_up register
  localparam int unsigned WakeUpReg   = 1;

  // memory map, lowest address last
  // 0x00 eoc         rw
  // 0x04 wake_up     rw
  // 0x08 tcdm_start  ro
  // 0x0c tcdm_end    ro
  // 0x10 num_cores   ro
  typedef struct packed {
    data_t     num_cores;
    data_t     tcdm_end;
    data_t     tcdm_start;
    data_t     wake_up;
    eoc_word_u eoc;
  } regs_t;

  localparam logic [NumRegs-1:0][DataWidth-1:0] RegRstVal = {
    data_t'(NumCores),
    TcdmBaseAddr + TcdmSize,
    TcdmBaseAddr,
    data_t'(0),
    data_t'(0)
  };

  // top three words cannot be written from the bus
  localparam logic [NumRegs-1:0][StrbWidth-1:0] ReadOnlyMask = {
    {StrbWidth{1'b1}},
    {StrbWidth{1'b1}},
    {StrbWidth{1'b1}},
    {StrbWidth{1'b0}},
    {StrbWidth{1'b0}}
  };

  logic [RegNumBytes-1:0]      wr_active;
  logic [RegNumBytes-1:0][7:0] reg_q;
  regs_t                       regs;
  // wake_up byte writes, one cycle late
  strb_t                       wake_wr_q;

  axi_lite_regs #(
    .RegNumBytes  (RegNumBytes ),
    .ReadOnlyMask (ReadOnlyMask),
    .RegRstVal    (RegRstVal   )
  ) i_axi_lite_regs (
    .clk_i        (clk_i          ),
    .reset_i      (reset_i        ),
    .axi_req_i    (axi_lite_req_i ),
    .axi_resp_o   (axi_lite_resp_o),
    .wr_active_o  (wr_active      ),
    .reg_q_o      (reg_q          )
  );

  assign regs = regs_t'(reg_q);

  // eoc viewed as code plus valid flag
  assign eoc_code_o  = regs.eoc.fields.code;
  assign eoc_valid_o = regs.eoc.fields.valid;

  assign tcdm_start_addr_o = regs.tcdm_start;
  assign tcdm_end_addr_o   = regs.tcdm_end;
  assign num_cores_o       = regs.num_cores;

  // delay so the decoder sees the word after it has been stored
  // this lines the pulse up with the first b_valid cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_wr_q <= '0;
    end else begin
      wake_wr_q <= wr_active[WakeUpReg*StrbWidth +: StrbWidth];
    end
  end

  // core index wakes one core, all ones wakes the cluster
  // any other value is dropped
  always_comb begin
    wake_up_o = '0;
    if (wake_wr_q != '0) begin
      if (regs.wake_up == '1) begin
        wake_up_o = '1;
      end else begin
        for (int unsigned c = 0; c < NumCores; c++) begin
          if (regs.wake_up == data_t'(c)) begin
            wake_up_o[c] = 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cluster_ctrl_top.sv
// cluster control block top level, fixes the cluster configuration around the register map
`default_nettype none

module cluster_ctrl_top
  import cluster_ctrl_pkg::*;
#(
  // eight cores per cluster
  parameter int unsigned NumCores     = 8,
  // 64 KiB of TCDM at the start of the cluster window
  parameter data_t       TcdmBaseAddr = 32'h1000_0000,
  parameter data_t       TcdmSize     = 32'h0001_0000
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // AXI-Lite slave port from cores and host
  input  axi_lite_req_t        axi_lite_req_i,
  output axi_lite_resp_t       axi_lite_resp_o,
  // end of computation
  output logic [DataWidth-2:0] eoc_code_o,
  output logic                 eoc_valid_o,
  // one-cycle pulse per core
  output logic [NumCores-1:0]  wake_up_o,
  // memory map constants
  output data_t                tcdm_start_addr_o,
  output data_t                tcdm_end_addr_o,
  output data_t                num_cores_o
);

  // all registers, decode and wake-up logic live here
  ctrl_registers #(
    .NumCores     (NumCores    ),
    .TcdmBaseAddr (TcdmBaseAddr),
    .TcdmSize     (TcdmSize    )
  ) i_ctrl_registers (
    .clk_i             (clk_i            ),
    .reset_i           (reset_i          ),
    .axi_lite_req_i    (axi_lite_req_i   ),
    .axi_lite_resp_o   (axi_lite_resp_o  ),
    .eoc_code_o        (eoc_code_o       ),
    .eoc_valid_o       (eoc_valid_o      ),
    .wake_up_o         (wake_up_o        ),
    .tcdm_start_addr_o (tcdm_start_addr_o),
    .tcdm_end_addr_o   (tcdm_end_addr_o  ),
    .num_cores_o       (num_cores_o      )
  );

endmodule

`default_nettype wire

// File: tests/tb_axi_lite_tasks.svh
// AXI-Lite master tasks and LFSR stimulus source for the cluster control testbench
`ifndef TB_AXI_LITE_TASKS_SVH
`define TB_AXI_LITE_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic data_t rand_bits(input int unsigned n);
  data_t val;
  logic  fb;
  val = '0;
  for (int unsigned i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    val    = {val[30:0], fb};
  end
  return val;
endfunction

// aw and w go out together, returns at the handshake edge
task automatic send_write(input addr_t addr, input data_t data, input strb_t strb,
                          output time accepted);
  int unsigned cnt;
  cnt = 0;
  @(posedge clk_i);
  axi_req.aw_addr  <= addr;
  axi_req.aw_valid <= 1'b1;
  axi_req.w_data   <= data;
  axi_req.w_strb   <= strb;
  axi_req.w_valid  <= 1'b1;
  @(negedge clk_i);
  while (!(axi_resp.aw_ready && axi_resp.w_ready)) begin
    cnt++;
    if (cnt > Timeout) begin
      report_timeout("the write address and data handshake");
    end
    @(negedge clk_i);
  end
  @(posedge clk_i);
  accepted = $time;
  axi_req.aw_valid <= 1'b0;
  axi_req.w_valid  <= 1'b0;
endtask

// b_ready stays low for stall cycles after b_valid rises
task automatic take_write_resp(input int unsigned stall, output resp_t rsp,
                               output logic [NumCoresTb-1:0] wake, output time done);
  int unsigned cnt;
  int unsigned i;
  cnt = 0;
  @(negedge clk_i);
  while (!axi_resp.b_valid) begin
    cnt++;
    if (cnt > Timeout) begin
      report_timeout("the write response");
    end
    @(negedge clk_i);
  end
  assert (cnt == 0) else report_mismatch("b_valid not one cycle after the write handshake");
  rsp  = axi_resp.b_resp;
  // pulse belongs to the first b_valid cycle
  wake = wake_up;
  for (i = 0; i <= stall; i++) begin
    if (i == stall) begin
      @(posedge clk_i);
      axi_req.b_ready <= 1'b1;
    end
    @(negedge clk_i);
    assert (axi_resp.b_valid && axi_resp.b_resp == rsp)
      else report_mismatch("write response changed before b_ready");
    assert (!axi_resp.aw_ready && !axi_resp.w_ready)
      else report_mismatch("write accepted while a response is pending");
    assert (wake_up == '0) else report_mismatch("wake-up pulse longer than one cycle");
  end
  @(posedge clk_i);
  done = $time;
  axi_req.b_ready <= 1'b0;
endtask

task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                         output resp_t rsp, output logic [NumCoresTb-1:0] wake);
  time t_acc;
  time t_done;
  send_write(addr, data, strb, t_acc);
  take_write_resp(0, rsp, wake, t_done);
endtask

// r_ready stays low for stall cycles after r_valid rises
task automatic axi_read(input addr_t addr, input int unsigned stall,
                        output data_t data, output resp_t rsp);
  int unsigned cnt;
  int unsigned i;
  cnt = 0;
  @(posedge clk_i);
  axi_req.ar_addr  <= addr;
  axi_req.ar_valid <= 1'b1;
  @(negedge clk_i);
  while (!axi_resp.ar_ready) begin
    cnt++;
    if (cnt > Timeout) begin
      report_timeout("the read address handshake");
    end
    @(negedge clk_i);
  end
  @(posedge clk_i);
  axi_req.ar_valid <= 1'b0;
  cnt = 0;
  @(negedge clk_i);
  while (!axi_resp.r_valid) begin
    cnt++;
    if (cnt > Timeout) begin
      report_timeout("the read response");
    end
    @(negedge clk_i);
  end
  assert (cnt == 0) else report_mismatch("r_valid not one cycle after the read handshake");
  data = axi_resp.r_data;
  rsp  = axi_resp.r_resp;
  for (i = 0; i <= stall; i++) begin
    if (i == stall) begin
      @(posedge clk_i);
      axi_req.r_ready <= 1'b1;
    end
    @(negedge clk_i);
    assert (axi_resp.r_valid && axi_resp.r_data == data && axi_resp.r_resp == rsp)
      else report_mismatch("read response changed before r_ready");
  end
  @(posedge clk_i);
  axi_req.r_ready <= 1'b0;
endtask

`endif

// File: tests/tb_cluster_ctrl.sv
// testbench running directed AXI-Lite tests over the cluster control register map
`default_nettype none

module tb_cluster_ctrl
  import cluster_ctrl_pkg::*;
;

  localparam int unsigned NumCoresTb = 8;
  localparam data_t       TcdmBase   = 32'h1000_0000;
  localparam data_t       TcdmEnd    = 32'h1001_0000;
  // cycles any single wait may take
  localparam int unsigned Timeout    = 50;

  logic                  clk_i;
  logic                  reset_i;
  axi_lite_req_t         axi_req;
  axi_lite_resp_t        axi_resp;
  logic [DataWidth-2:0]  eoc_code;
  logic                  eoc_valid;
  logic [NumCoresTb-1:0] wake_up;
  data_t                 tcdm_start;
  data_t                 tcdm_end;
  data_t                 num_cores;
  logic [31:0]           lfsr_q    = 32'h5ad6;
  // expected content of the eoc register
  data_t                 eoc_model = '0;

  always #2 clk_i = ~clk_i;

  cluster_ctrl_top UUT (
    .clk_i             (clk_i     ),
    .reset_i           (reset_i   ),
    .axi_lite_req_i    (axi_req   ),
    .axi_lite_resp_o   (axi_resp  ),
    .eoc_code_o        (eoc_code  ),
    .eoc_valid_o       (eoc_valid ),
    .wake_up_o         (wake_up   ),
    .tcdm_start_addr_o (tcdm_start),
    .tcdm_end_addr_o   (tcdm_end  ),
    .num_cores_o       (num_cores )
  );

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t waiting for %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "wait timed out");
  endtask

  `include "tb_axi_lite_tasks.svh"

  // memory map after reset by word index 0 to 4
  function automatic data_t expected_reset(input int unsigned idx);
    case (idx)
      2:       return TcdmBase;
      3:       return TcdmEnd;
      4:       return data_t'(NumCoresTb);
      default: return '0;
    endcase
  endfunction

  // strobed bytes of nxt replace those of old
  function automatic data_t merge_bytes(input data_t old, input data_t nxt, input strb_t strb);
    data_t res;
    res = old;
    for (int unsigned b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = nxt[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic read_reset_values();
    data_t       rdata;
    resp_t       rsp;
    int unsigned r;
    @(negedge clk_i);
    assert (axi_resp.aw_ready && axi_resp.w_ready && axi_resp.ar_ready)
      else report_mismatch("ready low after reset");
    assert (!axi_resp.b_valid && !axi_resp.r_valid && wake_up == '0)
      else report_mismatch("response or wake-up active after reset");
    assert (tcdm_start == TcdmBase && tcdm_end == TcdmEnd && num_cores == 32'd8 && !eoc_valid)
      else report_mismatch("constant outputs or eoc_valid wrong after reset");
    for (r = 0; r < NumRegs; r++) begin
      axi_read(addr_t'(4 * r), 0, rdata, rsp);
      assert (rdata == expected_reset(r) && rsp == RespOkay)
        else report_mismatch($sformatf("reset read of word %0d gave %h", r, rdata));
    end
  endtask

  task automatic protect_read_only();
    data_t                 rdata;
    resp_t                 rsp;
    logic [NumCoresTb-1:0] wake;
    int unsigned           r;
    for (r = 2; r < NumRegs; r++) begin
      axi_write(addr_t'(4 * r), rand_bits(32), strb_t'(rand_bits(4)) | 4'h1, rsp, wake);
      assert (rsp == RespSlvErr && wake == '0)
        else report_mismatch("write to read-only word not rejected or woke a core");
      axi_read(addr_t'(4 * r), 0, rdata, rsp);
      assert (rdata == expected_reset(r) && rsp == RespOkay)
        else report_mismatch($sformatf("read-only word %0d changed to %h", r, rdata));
    end
    // 0x14, 0x88 and 0xfc lie past the map
    for (r = 5; r < 64; r += 29) begin
      axi_write(addr_t'(4 * r), rand_bits(32), 4'hf, rsp, wake);
      assert (rsp == RespSlvErr && wake == '0)
        else report_mismatch("write outside the map not rejected or woke a core");
      axi_read(addr_t'(4 * r), 0, rdata, rsp);
      assert (rsp == RespSlvErr && rdata == '0)
        else report_mismatch($sformatf("read at word %0d gave %h", r, rdata));
    end
  endtask

  task automatic merge_eoc_strobes();
    data_t                 wdata;
    data_t                 rdata;
    strb_t                 strb;
    resp_t                 rsp;
    logic [NumCoresTb-1:0] wake;
    for (int unsigned n = 0; n < 12; n++) begin
      wdata = rand_bits(32);
      strb  = strb_t'(rand_bits(4));
      axi_write(8'h00, wdata, strb, rsp, wake);
      assert (rsp == RespOkay && wake == '0)
        else report_mismatch($sformatf("eoc write gave response %b and wake-up %b", rsp, wake));
      eoc_model = merge_bytes(eoc_model, wdata, strb);
      axi_read(8'h00, 0, rdata, rsp);
      assert (rsp == RespOkay && rdata == eoc_model)
        else report_mismatch($sformatf("eoc read %h, expected %h", rdata, eoc_model));
      assert (eoc_code == eoc_model[31:1] && eoc_valid == eoc_model[0])
        else report_mismatch("eoc code or valid output wrong");
    end
  endtask

  task automatic decode_wake_up();
    data_t                 val;
    data_t                 rdata;
    resp_t                 rsp;
    logic [NumCoresTb-1:0] wake;
    logic [NumCoresTb-1:0] exp_wake;
    for (int unsigned c = 0; c < NumCoresTb + 3; c++) begin
      exp_wake = '0;
      if (c < NumCoresTb) begin
        val         = data_t'(c);
        exp_wake[c] = 1'b1;
      end else if (c == NumCoresTb) begin
        val      = '1;
        exp_wake = '1;
      end else begin
        // no core has this index
        val = rand_bits(32) | 32'h100;
        if (val == '1) begin
          val = 32'h100;
        end
      end
      axi_write(8'h04, val, 4'hf, rsp, wake);
      assert (rsp == RespOkay && wake == exp_wake)
        else report_mismatch($sformatf("wake-up for %h gave %b", val, wake));
      axi_read(8'h04, 0, rdata, rsp);
      assert (rsp == RespOkay && rdata == val) else report_mismatch("wake_up read-back differs");
    end
  endtask

  task automatic stall_responses();
    data_t                 data_a;
    data_t                 data_b;
    data_t                 rdata;
    resp_t                 rsp_a;
    resp_t                 rsp_b;
    logic [NumCoresTb-1:0] wake_a;
    logic [NumCoresTb-1:0] wake_b;
    time                   acc_a;
    time                   acc_b;
    time                   done_a;
    time                   done_b;
    data_a = rand_bits(32);
    data_b = rand_bits(32);
    send_write(8'h00, data_a, 4'hf, acc_a);
    // second write waits behind the stalled response
    fork
      take_write_resp(1 + rand_bits(3), rsp_a, wake_a, done_a);
      begin
        send_write(8'h00, data_b, 4'b0101, acc_b);
        take_write_resp(1 + rand_bits(3), rsp_b, wake_b, done_b);
      end
    join
    assert (rsp_a == RespOkay && rsp_b == RespOkay && wake_a == '0 && wake_b == '0)
      else report_mismatch("stalled writes gave a wrong response or a wake-up");
    assert (acc_b > done_a) else report_mismatch("second write accepted before first response");
    eoc_model = merge_bytes(merge_bytes(eoc_model, data_a, 4'hf), data_b, 4'b0101);
    axi_read(8'h00, 1 + rand_bits(3), rdata, rsp_a);
    assert (rsp_a == RespOkay && rdata == eoc_model)
      else report_mismatch($sformatf("eoc after stalled writes %h, expected %h", rdata, eoc_model));
  endtask

  initial begin
    clk_i   = 1'b0;
    reset_i = 1'b1;
    axi_req = '0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    read_reset_values();
    protect_read_only();
    merge_eoc_strobes();
    decode_wake_up();
    stall_responses();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: cluster_ctrl.f
+incdir+tests
source/cluster_ctrl_pkg.sv
source/axi_lite_regs.sv
source/ctrl_registers.sv
source/cluster_ctrl_top.sv
tests/tb_cluster_ctrl.sv

// File: Bender.yml
package:
  name: cluster_ctrl

sources:
  - source/cluster_ctrl_pkg.sv
  - source/axi_lite_regs.sv
  - source/ctrl_registers.sv
  - source/cluster_ctrl_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cluster_ctrl.sv
